//--- Bender.yml
package:
  name: lp20

sources:
  - include_dirs:
      - common
    files:
      - common/lpBusPkg.sv
      - common/lpRegPkg.sv
      - common/lpIfs.sv
      - design/lpCbuf.sv
      - lpDma/lpDmaEngine.sv
      - design/lpCsr.sv
      - design/lp20Top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/lp20_assert.sv
      - tests/lp20Tb.sv

//--- common/lp20_consts.svh
/*
 * Widths and register bit positions for the LP20 printer DMA controller.
 * Included by the packages and by every RTL file that sizes a bus or
 * decodes a register field.
 */

`ifndef LP20_CONSTS_SVH
`define LP20_CONSTS_SVH

////////////////////////////////////////////////////////////
// Bus and register widths
////////////////////////////////////////////////////////////

// Memory and register data word
`define LP_WORD_W 36
// Byte address, four bytes per word
`define LP_BAR_W 18
// Byte count
`define LP_CNT_W 12
// Register select on the slave port
`define LP_ADR_W 2

////////////////////////////////////////////////////////////
// CSRA bit positions
////////////////////////////////////////////////////////////

`define LP_CSRA_GO   0
`define LP_CSRA_INIT 1
`define LP_CSRA_DONE 2
`define LP_CSRA_IE   3

// CBUF value from a written word
`define lpCBUF_DAT(dat) (dat[7:0])

`endif

//--- common/lpBusPkg.sv
/*
 * Bus-level types for the LP20 controller.
 * One 36-bit word seen either as packed printer bytes or as an
 * 18-bit register value, depending on who decodes it.
 */

`include "lp20_consts.svh"

package lpBusPkg;

   // Four 8-bit characters in a 36-bit word
   // Each 18-bit half has 2 pad bits on top
   typedef struct packed {
      logic [1:0] padEven;
      logic [7:0] hiEven;
      logic [7:0] loEven;
      logic [1:0] padOdd;
      logic [7:0] hiOdd;
      logic [7:0] loOdd;
   } lpByteWord_t;

   // Register access uses the low half only
   typedef struct packed {
      logic [`LP_WORD_W-`LP_BAR_W-1:0] unused;
      logic [`LP_BAR_W-1:0]            value;
   } lpRegWord_t;

   // Same bits, two decodings
   typedef union packed {
      lpByteWord_t byteView;
      lpRegWord_t  regView;
   } lpWord_t;

endpackage

//--- common/lpIfs.sv
/*
 * Interfaces inside the LP20 controller.
 * lpCtlIf links the register block to the DMA engine and lpCbufIf
 * carries the data path into the character buffer.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

////////////////////////////////////////////////////////////
// Control path, register block to DMA engine
////////////////////////////////////////////////////////////

interface lpCtlIf;
   // One-cycle command pulses
   logic                 start;
   logic                 init;
   // Register loads from the CPU
   logic                 barLoad;
   logic                 cntLoad;
   logic [`LP_BAR_W-1:0] barData;
   logic [`LP_CNT_W-1:0] cntData;
   // Engine status
   logic [`LP_BAR_W-1:0] bar;
   logic [`LP_CNT_W-1:0] cnt;
   logic                 busy;
   logic                 donePulse;

   modport csr (output start, init, barLoad, cntLoad, barData, cntData,
                input  bar, cnt, busy, donePulse);
   modport dma (input  start, init, barLoad, cntLoad, barData, cntData,
                output bar, cnt, busy, donePulse);
endinterface

////////////////////////////////////////////////////////////
// Data path into the character buffer
////////////////////////////////////////////////////////////

interface lpCbufIf;
   import lpBusPkg::*;

   logic                 devReq;
   logic                 devAck;
   lpWord_t              dataIn;
   logic [`LP_BAR_W-1:0] bar;
   logic                 cbufWrite;
   logic                 init;
   logic [7:0]           cbuf;

   modport dma    (output devReq, bar);
   modport csr    (output cbufWrite, init);
   modport buffer (input devReq, devAck, dataIn, bar, cbufWrite, init, output cbuf);
endinterface

//--- common/lpRegPkg.sv
/*
 * Programmer-visible register types for the LP20 controller.
 * Holds the register address map and the CSRA layout used for
 * readback by the register block and the testbench.
 */

`include "lp20_consts.svh"

package lpRegPkg;

   // Register address map
   typedef enum logic [`LP_ADR_W-1:0] {
      CSRA = 2'd0,
      BAR  = 2'd1,
      BCTR = 2'd2,
      CBUF = 2'd3
   } lpRegAddr_e;

   // CSRA field layout, msb first
   // Bit order matches the LP_CSRA_* positions
   typedef struct packed {
      // Interrupt enable
      logic ie;
      // Sticky transfer complete
      logic done;
      // Init command, reads as zero
      logic init;
      // Go on write, busy on read
      logic go;
   } lpCsra_t;

endpackage

//--- design/lp20Top.sv
/*
 * Top of the LP20 printer DMA controller.
 * Connects the register block, DMA engine and character buffer, and
 * exposes the slave, master and printer ports as plain signals.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lp20Top (
   input  logic                    clk,
   input  logic                    arstN,
   // Wishbone slave from the CPU
   input  logic                    wbsCyc,
   input  logic                    wbsStb,
   input  logic                    wbsWe,
   input  logic [`LP_ADR_W-1:0]    wbsAdr,
   input  logic [`LP_WORD_W-1:0]   wbsDatI,
   output logic [`LP_WORD_W-1:0]   wbsDatO,
   output logic                    wbsAck,
   // Wishbone master to memory
   output logic                    wbmCyc,
   output logic                    wbmStb,
   output logic [`LP_BAR_W-3:0]    wbmAdr,
   input  logic [`LP_WORD_W-1:0]   wbmDatI,
   input  logic                    wbmAck,
   // Printer
   output logic                    lptValid,
   output logic [7:0]              lptData,
   input  logic                    lptReady,
   output logic                    irq
);
   import lpRegPkg::*;

   lpRegAddr_e wbsAdrE;

   lpCtlIf  ctlIf ();
   lpCbufIf cbufIf ();

   assign wbsAdrE = lpRegAddr_e'(wbsAdr);

   // Buffer data comes from the CPU on a CBUF write, else from memory
   assign cbufIf.dataIn = cbufIf.cbufWrite ? wbsDatI : wbmDatI;
   assign cbufIf.devAck = wbmAck;
   assign lptData       = cbufIf.cbuf;

   lpCsr i_csr (
      .clk      (clk),
      .arstN    (arstN),
      .wbsCyc   (wbsCyc),
      .wbsStb   (wbsStb),
      .wbsWe    (wbsWe),
      .wbsAdr   (wbsAdrE),
      .wbsDatI  (wbsDatI),
      .wbsDatO  (wbsDatO),
      .wbsAck   (wbsAck),
      .irq      (irq),
      .cbufVal  (cbufIf.cbuf),
      .ctl      (ctlIf.csr),
      .cbufPort (cbufIf.csr)
   );

   lpDmaEngine i_dma (
      .clk      (clk),
      .arstN    (arstN),
      .wbmAck   (wbmAck),
      .wbmCyc   (wbmCyc),
      .wbmStb   (wbmStb),
      .wbmAdr   (wbmAdr),
      .lptReady (lptReady),
      .lptValid (lptValid),
      .ctl      (ctlIf.dma),
      .cbufPort (cbufIf.dma)
   );

   lpCbuf i_cbuf (
      .clk      (clk),
      .arstN    (arstN),
      .cbufPort (cbufIf.buffer)
   );

endmodule

//--- design/lpCbuf.sv
/*
 * Character buffer register of the LP20 controller.
 * Loads one byte of a DMA word, picked by the low BAR bits, or takes a
 * direct CPU write. Its value is the character offered to the printer.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lpCbuf (
   input  logic   clk,
   input  logic   arstN,
   lpCbufIf.buffer cbufPort
);

   // Byte picked from the memory word
   logic [7:0] byteSel;

   ////////////////////////////////////////////////////////////
   // Byte lane select
   ////////////////////////////////////////////////////////////

   // Even half first, low byte before high byte
   always_comb
   begin
      case (cbufPort.bar[1:0])
         // Even half, low byte
         2'b00: byteSel = cbufPort.dataIn.byteView.loEven;
         // Even half, high byte
         2'b01: byteSel = cbufPort.dataIn.byteView.hiEven;
         // Odd half, low byte
         2'b10: byteSel = cbufPort.dataIn.byteView.loOdd;
         default: byteSel = cbufPort.dataIn.byteView.hiOdd;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // CBUF register
   ////////////////////////////////////////////////////////////

   // Init clears it, CPU write beats a DMA load
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         cbufPort.cbuf <= 8'h00;
      else if (cbufPort.init)
         cbufPort.cbuf <= 8'h00;
      else if (cbufPort.cbufWrite)
         cbufPort.cbuf <= `lpCBUF_DAT(cbufPort.dataIn);
      // Memory read acknowledged
      else if (cbufPort.devReq && cbufPort.devAck)
         cbufPort.cbuf <= byteSel;
   end

endmodule

//--- design/lpCsr.sv
/*
 * Register block of the LP20 controller on a Wishbone classic slave.
 * Decodes CSRA, BAR, BCTR and CBUF accesses, issues the start, init and
 * load pulses, and keeps ie and the sticky done bit that drive irq.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lpCsr (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic                  wbsCyc,
   input  logic                  wbsStb,
   input  logic                  wbsWe,
   input  lpRegPkg::lpRegAddr_e  wbsAdr,
   input  lpBusPkg::lpWord_t     wbsDatI,
   output logic [`LP_WORD_W-1:0] wbsDatO,
   output logic                  wbsAck,
   output logic                  irq,
   input  logic [7:0]            cbufVal,
   lpCtlIf.csr                   ctl,
   lpCbufIf.csr                  cbufPort
);
   import lpRegPkg::*;

   logic                  access;
   logic                  wrEn;
   logic                  csraWr;
   logic                  goBit;
   logic                  initBit;
   logic                  ie;
   logic                  done;
   logic                  initQ;
   lpCsra_t               csraRd;
   logic [`LP_WORD_W-1:0] rdData;

   // New cycle seen, ack goes out on the next edge
   assign access  = wbsCyc && wbsStb && !wbsAck;
   assign wrEn    = access && wbsWe;
   assign csraWr  = wrEn && (wbsAdr == CSRA);
   assign goBit   = wbsDatI.regView.value[`LP_CSRA_GO];
   assign initBit = wbsDatI.regView.value[`LP_CSRA_INIT];

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   // Loads land on the ack edge
   assign ctl.barLoad        = wrEn && (wbsAdr == BAR);
   assign ctl.cntLoad        = wrEn && (wbsAdr == BCTR);
   assign ctl.barData        = wbsDatI.regView.value;
   assign ctl.cntData        = wbsDatI.regView.value[`LP_CNT_W-1:0];
   assign cbufPort.cbufWrite = wrEn && (wbsAdr == CBUF);
   assign ctl.init           = initQ;
   assign cbufPort.init      = initQ;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         wbsAck    <= 1'b0;
         ctl.start <= 1'b0;
         initQ     <= 1'b0;
         ie        <= 1'b0;
         done      <= 1'b0;
      end
      else
      begin
         wbsAck    <= access;
         // Init wins over go in the same write
         ctl.start <= csraWr && goBit && !initBit;
         initQ     <= csraWr && initBit;
         if (csraWr)
            ie <= wbsDatI.regView.value[`LP_CSRA_IE];
         // Sticky done, cleared by go or init
         if (initQ)
            done <= 1'b0;
         else if (csraWr && (goBit || initBit))
            done <= 1'b0;
         else if (ctl.donePulse)
            done <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      csraRd = '{ie: ie, done: done, init: 1'b0, go: ctl.busy};
      rdData = '0;
      case (wbsAdr)
         CSRA:    rdData[`LP_CSRA_IE:`LP_CSRA_GO] = csraRd;
         BAR:     rdData[`LP_BAR_W-1:0] = ctl.bar;
         BCTR:    rdData[`LP_CNT_W-1:0] = ctl.cnt;
         default: rdData[7:0] = cbufVal;
      endcase
   end

   // Valid together with ack
   always_ff @(posedge clk)
   begin
      if (access)
         wbsDatO <= rdData;
   end

   assign irq = done && ie;

endmodule

//--- lp20.f
+incdir+common
common/lpBusPkg.sv
common/lpRegPkg.sv
common/lpIfs.sv
design/lpCbuf.sv
lpDma/lpDmaEngine.sv
design/lpCsr.sv
design/lp20Top.sv
tests/lp20_assert.sv
tests/lp20Tb.sv

//--- lpDma/lpDmaEngine.sv
/*
 * DMA sequencer of the LP20 controller.
 * Reads one memory word per character over a Wishbone classic master,
 * offers the buffered character to the printer, then steps BAR and the
 * byte count. Pulses donePulse when the count runs out.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lpDmaEngine (
   input  logic                   clk,
   input  logic                   arstN,
   input  logic                   wbmAck,
   output logic                   wbmCyc,
   output logic                   wbmStb,
   output logic [`LP_BAR_W-3:0]   wbmAdr,
   input  logic                   lptReady,
   output logic                   lptValid,
   lpCtlIf.dma                    ctl,
   lpCbufIf.dma                   cbufPort
);

   // Idle, memory read, printer handshake
   typedef enum logic [1:0] {
      Idle,
      Fetch,
      Print
   } dmaState_e;

   dmaState_e            state;
   dmaState_e            nextState;
   logic [`LP_BAR_W-1:0] barQ;
   logic [`LP_CNT_W-1:0] cntQ;
   // Character accepted by the printer
   logic                 xfer;
   logic                 lastChar;

   assign xfer     = (state == Print) && lptReady;
   assign lastChar = (cntQ == `LP_CNT_W'(1));

   ////////////////////////////////////////////////////////////
   // Next state and done
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      nextState     = state;
      ctl.donePulse = 1'b0;
      // Init aborts without a done
      if (ctl.init)
         nextState = Idle;
      else
      begin
         case (state)
            Idle:
               if (ctl.start)
               begin
                  // Zero count finishes at once
                  if (cntQ == '0)
                     ctl.donePulse = 1'b1;
                  else
                     nextState = Fetch;
               end
            Fetch:
               if (wbmAck)
                  nextState = Print;
            Print:
               if (lptReady)
               begin
                  if (lastChar)
                  begin
                     nextState     = Idle;
                     ctl.donePulse = 1'b1;
                  end
                  else
                     nextState = Fetch;
               end
            default:
               nextState = Idle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // State, address and count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state <= Idle;
         barQ  <= '0;
         cntQ  <= '0;
      end
      else
      begin
         state <= nextState;
         // CPU loads only between transfers
         if (state == Idle)
         begin
            if (ctl.barLoad)
               barQ <= ctl.barData;
            if (ctl.cntLoad)
               cntQ <= ctl.cntData;
         end
         // Step on each printed character
         else if (xfer && !ctl.init)
         begin
            barQ <= barQ + 1'b1;
            cntQ <= cntQ - 1'b1;
         end
      end
   end

   // Bus and printer strobes come straight from state
   // so they hold steady while waiting
   assign wbmCyc          = (state == Fetch);
   assign wbmStb          = (state == Fetch);
   assign wbmAdr          = barQ[`LP_BAR_W-1:2];
   assign lptValid        = (state == Print);
   assign cbufPort.devReq = (state == Fetch);
   assign cbufPort.bar    = barQ;
   assign ctl.busy        = (state != Idle);
   assign ctl.bar         = barQ;
   assign ctl.cnt         = cntQ;

endmodule

//--- tests/lp20Tb.sv
/*
 * Testbench for the LP20 printer DMA controller.
 * Holds the clock, a Wishbone memory model, a printer model, the table
 * of transfers and the checks. Binds the protocol assertions into the DUT.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lp20Tb;
   import lpRegPkg::*;

   localparam int NUM_TESTS = 5;

   logic                   clk;
   logic                   arstN;
   logic                   wbsCyc;
   logic                   wbsStb;
   logic                   wbsWe;
   logic [`LP_ADR_W-1:0]   wbsAdr;
   logic [`LP_WORD_W-1:0]  wbsDatI;
   logic [`LP_WORD_W-1:0]  wbsDatO;
   logic                   wbsAck;
   logic                   wbmCyc;
   logic                   wbmStb;
   logic [`LP_BAR_W-3:0]   wbmAdr;
   logic [`LP_WORD_W-1:0]  wbmDatI;
   logic                   wbmAck;
   logic                   lptValid;
   logic [7:0]             lptData;
   logic                   lptReady;
   logic                   irq;

   // Transfer table: start BAR, count, ie and final BAR
   string                tName[NUM_TESTS]   = '{"lane0_short", "lane1_cross", "lane2_ie",
                                                "wrap_top", "zero_count"};
   logic [`LP_BAR_W-1:0] tBar[NUM_TESTS]    = '{18'h00000, 18'h0000d, 18'h00022,
                                                18'h3fffb, 18'h00010};
   int                   tCnt[NUM_TESTS]    = '{5, 9, 17, 9, 0};
   bit                   tIe[NUM_TESTS]     = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
   logic [`LP_BAR_W-1:0] tExpBar[NUM_TESTS] = '{18'h00005, 18'h00016, 18'h00033,
                                                18'h00004, 18'h00010};

   logic [`LP_WORD_W-1:0] memWords[64];
   logic [7:0]            printed[$];
   logic [31:0]           lfsrState = 32'h5420_5ebb;
   logic [1:0]            ackDelay;
   logic [1:0]            memWait;
   logic                  readyRnd;
   int                    cycleCnt = 0;
   int                    cycleLimit = 0;
   string                 curName;
   bit                    testOk;
   int                    passCnt = 0;
   int                    failCnt = 0;

   lp20Top i_dut (.*);

   bind lp20Top lp20Assert i_assert (
      .clk       (clk),
      .arstN     (arstN),
      .wbsAck    (wbsAck),
      .wbmCyc    (wbmCyc),
      .wbmStb    (wbmStb),
      .wbmAck    (wbmAck),
      .wbmAdr    (wbmAdr),
      .lptValid  (lptValid),
      .lptReady  (lptReady),
      .lptData   (lptData),
      .initPulse (ctlIf.init)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source, memory and printer models
   ////////////////////////////////////////////////////////////

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   task automatic drawBits(input int n, output logic [35:0] bits);
      int i;
      bits = '0;
      for (i = 0; i < n; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         bits = {bits[34:0], lfsrState[0]};
      end
   endtask

   always @(posedge clk)
   begin : randGen
      logic [35:0] bits;
      drawBits(2, bits);
      ackDelay <= bits[1:0];
      drawBits(1, bits);
      readyRnd <= bits[0];
   end

   // Registered ack after 0 to 3 wait cycles
   always @(posedge clk)
   begin
      if (!arstN)
      begin
         wbmAck  <= 1'b0;
         memWait <= 2'd0;
      end
      else if (wbmAck)
         wbmAck <= 1'b0;
      else if (wbmCyc && wbmStb)
      begin
         if (memWait == 2'd0)
         begin
            wbmAck  <= 1'b1;
            wbmDatI <= memWords[wbmAdr[5:0]];
         end
         else
            memWait <= memWait - 2'd1;
      end
      else
         memWait <= ackDelay;
   end

   // Printer with random ready, logs every accepted character
   always @(posedge clk)
   begin
      if (!arstN)
         lptReady <= 1'b0;
      else
         lptReady <= readyRnd;
      if (arstN && lptValid && lptReady)
         printed.push_back(lptData);
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCnt <= cycleCnt + 1;
      if (cycleLimit != 0 && cycleCnt >= cycleLimit)
      begin
         $display("Run stopped in %s after %0d cycles, limit reached", curName, cycleCnt);
         $display("sim failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Byte rule: even half on top, low byte first
   function automatic logic [7:0] expectedByte(input logic [35:0] w, input logic [1:0] lane);
      case (lane)
         2'd0:    expectedByte = w[25:18];
         2'd1:    expectedByte = w[33:26];
         2'd2:    expectedByte = w[7:0];
         default: expectedByte = w[15:8];
      endcase
   endfunction

   task automatic startTest(input string name);
      curName = name;
      testOk  = 1'b1;
   endtask

   task automatic endTest();
      if (testOk)
      begin
         $display("ok   %s", curName);
         passCnt++;
      end
      else
         failCnt++;
   endtask

   task automatic reportMismatch(input string what, input logic [35:0] expVal,
                                 input logic [35:0] actVal);
      $display("Fail %s %s: expected %0h, actual %0h", curName, what, expVal, actVal);
      testOk = 1'b0;
   endtask

   // One slave access, inputs driven on the rising edge
   task automatic busCycle(input lpRegAddr_e adr, input logic we, input logic [35:0] dat,
                           output logic [35:0] rd);
      int waitCnt;
      @(posedge clk);
      wbsCyc  <= 1'b1;
      wbsStb  <= 1'b1;
      wbsWe   <= we;
      wbsAdr  <= adr;
      wbsDatI <= dat;
      waitCnt = 0;
      do
      begin
         @(posedge clk);
         waitCnt++;
      end
      while (!wbsAck && waitCnt < 8);
      rd = wbsDatO;
      wbsCyc <= 1'b0;
      wbsStb <= 1'b0;
      wbsWe  <= 1'b0;
      if (testOk && !wbsAck)
      begin
         $display("%s: no acknowledge for register %s", curName, adr.name());
         testOk = 1'b0;
      end
   endtask

   // Poll CSRA until done
   task automatic waitDone(input int limit);
      logic [35:0] rd;
      int          startCycle;
      startCycle = cycleCnt;
      rd = '0;
      while (testOk && !rd[`LP_CSRA_DONE])
      begin
         if (cycleCnt - startCycle > limit)
         begin
            $display("%s: timeout waiting for done", curName);
            testOk = 1'b0;
         end
         else
            busCycle(CSRA, 1'b0, '0, rd);
      end
   endtask

   task automatic checkChars(input logic [`LP_BAR_W-1:0] startBar, input int n);
      logic [`LP_BAR_W-1:0] b;
      logic [7:0]           expChar;
      int                   i;
      for (i = 0; i < n && i < printed.size(); i++)
      begin
         b       = startBar + 18'(i);
         expChar = expectedByte(memWords[b[7:2]], b[1:0]);
         if (testOk && printed[i] !== expChar)
            reportMismatch($sformatf("char %0d", i), expChar, printed[i]);
      end
      if (testOk && printed.size() != n)
      begin
         $display("%s: %0d characters printed where %0d were expected",
                  curName, printed.size(), n);
         testOk = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial
   begin : mainSeq
      logic [35:0] rd;
      logic [35:0] csraVal;
      lpCsra_t     expCsra;
      int          sumCnt;
      int          seen;
      int          startCycle;
      int          assertFails;
      int          t;
      int          w;

      arstN    = 1'b0;
      wbsCyc   = 1'b0;
      wbsStb   = 1'b0;
      wbsWe    = 1'b0;
      wbsAdr   = '0;
      wbsDatI  = '0;
      wbmDatI  = '0;
      wbmAck   = 1'b0;
      lptReady = 1'b0;
      for (w = 0; w < 64; w++)
         drawBits(36, memWords[w]);
      // Init abort test counts as 40 characters
      sumCnt = 40;
      for (t = 0; t < NUM_TESTS; t++)
         sumCnt += tCnt[t];
      cycleLimit = 12 * sumCnt + 200 * (NUM_TESTS + 3);
      repeat (4) @(posedge clk);
      arstN <= 1'b1;

      // Reset values, then BAR and BCTR readback
      startTest("reset_values");
      busCycle(CBUF, 1'b0, '0, rd);
      if (testOk && rd !== 36'h0)
         reportMismatch("CBUF", 36'h0, rd);
      busCycle(CSRA, 1'b0, '0, rd);
      if (testOk && rd !== 36'h0)
         reportMismatch("CSRA", 36'h0, rd);
      busCycle(BAR, 1'b0, '0, rd);
      if (testOk && rd !== 36'h0)
         reportMismatch("BAR", 36'h0, rd);
      busCycle(BAR, 1'b1, 36'h0_0002_5a5c, rd);
      busCycle(BAR, 1'b0, '0, rd);
      if (testOk && rd !== 36'h2_5a5c)
         reportMismatch("BAR", 36'h2_5a5c, rd);
      busCycle(BCTR, 1'b1, 36'h0_0000_0abc, rd);
      busCycle(BCTR, 1'b0, '0, rd);
      if (testOk && rd !== 36'habc)
         reportMismatch("BCTR", 36'habc, rd);
      endTest();

      // DMA transfers from the table
      for (t = 0; t < NUM_TESTS; t++)
      begin
         startTest(tName[t]);
         printed.delete();
         busCycle(BAR, 1'b1, 36'(tBar[t]), rd);
         busCycle(BCTR, 1'b1, 36'(tCnt[t]), rd);
         csraVal = '0;
         csraVal[`LP_CSRA_GO] = 1'b1;
         csraVal[`LP_CSRA_IE] = tIe[t];
         busCycle(CSRA, 1'b1, csraVal, rd);
         waitDone(12 * tCnt[t] + 200);
         expCsra = '{ie: tIe[t], done: 1'b1, init: 1'b0, go: 1'b0};
         busCycle(CSRA, 1'b0, '0, rd);
         if (testOk && rd !== {32'd0, expCsra})
            reportMismatch("CSRA", {32'd0, expCsra}, rd);
         busCycle(BCTR, 1'b0, '0, rd);
         if (testOk && rd !== 36'h0)
            reportMismatch("BCTR", 36'h0, rd);
         busCycle(BAR, 1'b0, '0, rd);
         if (testOk && rd !== 36'(tExpBar[t]))
            reportMismatch("BAR", 36'(tExpBar[t]), rd);
         if (testOk && irq !== tIe[t])
            reportMismatch("irq", 36'(tIe[t]), 36'(irq));
         checkChars(tBar[t], tCnt[t]);
         endTest();
      end

      // Direct CPU write shows on the printer data
      startTest("cbuf_write");
      busCycle(CBUF, 1'b1, 36'h9_1234_56c3, rd);
      @(posedge clk);
      if (testOk && lptData !== 8'hc3)
         reportMismatch("lptData", 36'hc3, 36'(lptData));
      busCycle(CBUF, 1'b0, '0, rd);
      if (testOk && rd !== 36'hc3)
         reportMismatch("CBUF", 36'hc3, rd);
      endTest();

      // Init after a few characters of a long transfer
      startTest("init_abort");
      printed.delete();
      busCycle(BAR, 1'b1, 36'h0, rd);
      busCycle(BCTR, 1'b1, 36'd40, rd);
      busCycle(CSRA, 1'b1, 36'h9, rd);
      startCycle = cycleCnt;
      while (printed.size() < 3 && cycleCnt - startCycle < 200)
         @(posedge clk);
      if (testOk && printed.size() < 3)
      begin
         $display("%s: transfer did not start printing", curName);
         testOk = 1'b0;
      end
      // Init with ie kept set
      busCycle(CSRA, 1'b1, 36'ha, rd);
      @(posedge clk);
      seen = printed.size();
      // Quiet window after the abort
      repeat (20) @(posedge clk);
      if (testOk && printed.size() != seen)
      begin
         $display("%s: characters printed after init", curName);
         testOk = 1'b0;
      end
      if (testOk && lptValid)
      begin
         $display("%s: printer still offered a character after init", curName);
         testOk = 1'b0;
      end
      expCsra = '{ie: 1'b1, done: 1'b0, init: 1'b0, go: 1'b0};
      busCycle(CSRA, 1'b0, '0, rd);
      if (testOk && rd !== {32'd0, expCsra})
         reportMismatch("CSRA", {32'd0, expCsra}, rd);
      busCycle(CBUF, 1'b0, '0, rd);
      if (testOk && rd !== 36'h0)
         reportMismatch("CBUF", 36'h0, rd);
      checkChars(18'h0, seen);
      endTest();

      assertFails = i_dut.i_assert.failCount;
      if (assertFails != 0)
      begin
         $display("Protocol assertions failed %0d times", assertFails);
         failCnt++;
      end
      $display("%0d checks run, %0d ok, %0d failed", passCnt + failCnt, passCnt, failCnt);
      if (failCnt == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- tests/lp20_assert.sv
/*
 * Protocol assertions for the LP20 top level, bound into lp20Top.
 * Covers the master strobes, stability under back-pressure and the
 * width of the slave acknowledge.
 */

`timescale 1ns/10ps

`include "lp20_consts.svh"

module lp20Assert (
   input logic                 clk,
   input logic                 arstN,
   input logic                 wbsAck,
   input logic                 wbmCyc,
   input logic                 wbmStb,
   input logic                 wbmAck,
   input logic [`LP_BAR_W-3:0] wbmAdr,
   input logic                 lptValid,
   input logic                 lptReady,
   input logic [7:0]           lptData,
   input logic                 initPulse
);

   // Number of failed assertions so far
   int failCount = 0;

   ////////////////////////////////////////////////////////////
   // Wishbone master
   ////////////////////////////////////////////////////////////

   // Strobe only inside a cycle
   stbInCyc: assert property (@(posedge clk) disable iff (!arstN)
      wbmStb |-> wbmCyc)
   else
   begin
      $error("wbmStb high without wbmCyc");
      failCount++;
   end

   // Request held until acknowledged, unless an init aborts it
   reqHeld: assert property (@(posedge clk) disable iff (!arstN)
      (wbmCyc && wbmStb && !wbmAck && !initPulse) |=>
         (wbmCyc && wbmStb && $stable(wbmAdr)))
   else
   begin
      $error("memory request changed before wbmAck");
      failCount++;
   end

   ////////////////////////////////////////////////////////////
   // Printer and slave side
   ////////////////////////////////////////////////////////////

   // Character held while the printer stalls
   charHeld: assert property (@(posedge clk) disable iff (!arstN)
      (lptValid && !lptReady && !initPulse) |=> (lptValid && $stable(lptData)))
   else
   begin
      $error("printer character changed under back-pressure");
      failCount++;
   end

   // Single-cycle ack
   ackOneCycle: assert property (@(posedge clk) disable iff (!arstN)
      wbsAck |=> !wbsAck)
   else
   begin
      $error("wbsAck high for more than one cycle");
      failCount++;
   end

endmodule
